// File: router.f
+incdir+verilog
verilog/noc_pkg.sv
verilog/route_if.sv
verilog/input_port.sv
verilog/switch_allocator.sv
verilog/output_port.sv
verilog/router.sv
testbench/router_tb.sv

// File: testbench/router_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

module router_tb;
  import noc_pkg::*;

  localparam int TIMEOUT = 50; // cycles allowed for any single wait

  logic clk;
  logic reset;
  logic [`NUM_PORTS-1:0] in_req;
  logic [`FLIT_WIDTH-1:0] in_data [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] in_ack;
  logic [`NUM_PORTS-1:0] out_req;
  logic [`FLIT_WIDTH-1:0] out_data [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] out_ack;
  logic [31:0] lfsr_state;

  router #(
    .X_LOCATION(2'd1),
    .Y_LOCATION(2'd1)
  ) DUT (
    .clk(clk),
    .reset(reset),
    .in_req(in_req),
    .in_data(in_data),
    .in_ack(in_ack),
    .out_req(out_req),
    .out_data(out_data),
    .out_ack(out_ack)
  );

  always #5 clk = ~clk;

  task automatic fail(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_flit(input string name, input flit_u actual, input flit_u expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, actual.raw, expected.raw);
      fail("flit compare failed");
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
      fail("bit compare failed");
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic make_flit(input logic [1:0] x, input logic [1:0] y, output flit_u f);
    logic [31:0] bits;
    rand_bits(28, bits);
    f.hdr.x_dest = x;
    f.hdr.y_dest = y;
    f.hdr.payload = bits[27:0];
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
  endtask

  // full four-phase transfer into one input
  task automatic send_flit(input int port, input flit_u f);
    int n;
    @(negedge clk);
    in_data[port] = f.raw;
    in_req[port] = 1'b1;
    for (n = 0; n < TIMEOUT && !in_ack[port]; n++) @(negedge clk);
    if (!in_ack[port]) fail($sformatf("input %0d never raised in_ack", port));
    in_req[port] = 1'b0;
    for (n = 0; n < TIMEOUT && in_ack[port]; n++) @(negedge clk);
    if (in_ack[port]) fail($sformatf("input %0d never dropped in_ack", port));
  endtask

  task automatic wait_out_req(input int port);
    for (int n = 0; n < TIMEOUT && !out_req[port]; n++) @(negedge clk);
    if (!out_req[port]) fail($sformatf("output %0d never raised out_req", port));
  endtask

  task automatic expect_flit(input int port, input flit_u expected);
    wait_out_req(port);
    check_flit($sformatf("out_data[%0d]", port), out_data[port], expected);
    out_ack[port] = 1'b1;
    for (int n = 0; n < TIMEOUT && out_req[port]; n++) @(negedge clk);
    if (out_req[port]) fail($sformatf("output %0d never dropped out_req", port));
    out_ack[port] = 1'b0;
  endtask

  task automatic route_one(input int in_port, input logic [1:0] x, input logic [1:0] y,
                           input int out_port);
    flit_u f;
    make_flit(x, y, f);
    send_flit(in_port, f);
    expect_flit(out_port, f);
  endtask

  task automatic test_reset_state();
    for (int p = 0; p < `NUM_PORTS; p++) begin
      check_bit($sformatf("in_ack[%0d]", p), in_ack[p], 1'b0);
      check_bit($sformatf("out_req[%0d]", p), out_req[p], 1'b0);
    end
  endtask

  task automatic test_local();
    for (int p = 0; p < `NUM_PORTS; p++) route_one(p, 2'd1, 2'd1, `PORT_PE);
  endtask

  // column first, whatever the row
  task automatic test_column();
    for (int y = 0; y < 4; y++) begin
      route_one(y % `NUM_PORTS, 2'd2, y[1:0], `PORT_EAST);
      route_one((y + 1) % `NUM_PORTS, 2'd0, y[1:0], `PORT_WEST);
    end
  endtask

  task automatic test_row();
    route_one(`PORT_PE, 2'd1, 2'd2, `PORT_NORTH);
    route_one(`PORT_EAST, 2'd1, 2'd0, `PORT_SOUTH);
    route_one(`PORT_WEST, 2'd1, 2'd3, `PORT_NORTH);
    route_one(`PORT_SOUTH, 2'd1, 2'd0, `PORT_SOUTH);
  endtask

  task automatic test_backpressure();
    flit_u first;
    flit_u second;
    make_flit(2'd3, 2'd0, first);
    make_flit(2'd2, 2'd2, second);
    send_flit(`PORT_PE, first);
    wait_out_req(`PORT_EAST);
    send_flit(`PORT_SOUTH, second); // waits in its input buffer
    repeat (10) begin
      @(negedge clk);
      check_bit("out_req[east]", out_req[`PORT_EAST], 1'b1);
      check_flit("out_data[east]", out_data[`PORT_EAST], first);
    end
    expect_flit(`PORT_EAST, first);
    expect_flit(`PORT_EAST, second);
  endtask

  task automatic test_contention();
    flit_u a;
    flit_u b;
    make_flit(2'd2, 2'd1, a);
    make_flit(2'd3, 2'd3, b);
    fork
      send_flit(`PORT_PE, a);
      send_flit(`PORT_NORTH, b);
    join
    expect_flit(`PORT_EAST, a); // pointer starts at input 0
    expect_flit(`PORT_EAST, b);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    in_req = '0;
    out_ack = '0;
    for (int p = 0; p < `NUM_PORTS; p++) in_data[p] = '0;
    lfsr_state = 32'hc212;
    apply_reset();
    test_reset_state();
    test_local();
    test_column();
    test_row();
    test_backpressure();
    apply_reset();
    test_contention();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/input_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

module input_port #(
  parameter logic [`COORD_WIDTH-1:0] X_LOCATION = 2'd0,
  parameter logic [`COORD_WIDTH-1:0] Y_LOCATION = 2'd0
) (
  input  logic clk,
  input  logic reset,
  input  logic in_req,
  input  noc_pkg::flit_u in_data,
  output logic in_ack,
  route_if.buffer rt
);
  import noc_pkg::*;

  flit_u buf_flit;
  logic buf_full;
  logic accept;
  logic [`NUM_PORTS-1:0] dest;

  // new flit only once the previous handshake has returned to zero
  assign accept = in_req && !in_ack && !buf_full;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_ack <= 1'b0;
      buf_full <= 1'b0;
    end else begin
      if (accept) begin
        in_ack <= 1'b1;
        buf_full <= 1'b1;
      end else begin
        if (!in_req) begin
          in_ack <= 1'b0; // return to zero
        end
        if (rt.taken) begin
          buf_full <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      buf_flit <= in_data;
    end
  end

  // dimension-order routing, column first
  always_comb begin
    dest = '0;
    if (buf_flit.hdr.x_dest == X_LOCATION && buf_flit.hdr.y_dest == Y_LOCATION) begin
      dest[`PORT_PE] = 1'b1;
    end else if (buf_flit.hdr.x_dest > X_LOCATION) begin
      dest[`PORT_EAST] = 1'b1;
    end else if (buf_flit.hdr.x_dest < X_LOCATION) begin
      dest[`PORT_WEST] = 1'b1;
    end else if (buf_flit.hdr.y_dest > Y_LOCATION) begin
      dest[`PORT_NORTH] = 1'b1;
    end else begin
      dest[`PORT_SOUTH] = 1'b1; // column matches, row below
    end
  end

  assign rt.valid = buf_full;
  assign rt.dest = dest;
  assign rt.flit = buf_flit;

  a_dest_onehot: assert property (
    @(posedge clk) disable iff (reset) rt.valid |-> $onehot(rt.dest)
  );

  // allocator must only take a flit that is really here, and only once
  a_taken_valid: assert property (
    @(posedge clk) disable iff (reset) rt.taken |-> rt.valid ##1 !rt.valid
  );

endmodule

`default_nettype wire

// File: verilog/noc_defs.svh
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// flit geometry
`define FLIT_WIDTH 32
`define COORD_WIDTH 2
`define DEST_MSB 31 // x_dest sits on top, y_dest right below

`define NUM_PORTS 5

// port order used by every per-port array
`define PORT_PE 0
`define PORT_EAST 1
`define PORT_WEST 2
`define PORT_NORTH 3
`define PORT_SOUTH 4

`endif

// File: verilog/noc_pkg.sv
`default_nettype none

`include "noc_defs.svh"

package noc_pkg;

  typedef struct packed {
    logic [`COORD_WIDTH-1:0] x_dest;
    logic [`COORD_WIDTH-1:0] y_dest;
    logic [`DEST_MSB-2*`COORD_WIDTH:0] payload;
  } flit_hdr_t;

  // same 32 bits, seen as a channel word or as a routed header
  typedef union packed {
    logic [`FLIT_WIDTH-1:0] raw;
    flit_hdr_t hdr;
  } flit_u;

endpackage

`default_nettype wire

// File: verilog/output_port.sv
`timescale 1ns/1ns
`default_nettype none

module output_port (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  noc_pkg::flit_u flit,
  output logic busy,
  output logic out_req,
  output noc_pkg::flit_u out_data,
  input  logic out_ack
);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      out_req <= 1'b0;
    end else begin
      if (load) begin
        busy <= 1'b1;
        out_req <= 1'b1;
      end else if (out_req && out_ack) begin
        out_req <= 1'b0;
      end else if (busy && !out_req && !out_ack) begin
        busy <= 1'b0; // receiver back to idle
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= flit;
    end
  end

  a_data_stable: assert property (
    @(posedge clk) disable iff (reset) out_req && $past(out_req) |-> $stable(out_data)
  );

  // allocator must respect back-pressure
  a_load_idle: assert property (
    @(posedge clk) disable iff (reset) load |-> !busy && !out_req
  );

endmodule

`default_nettype wire

// File: verilog/route_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

interface route_if;
  import noc_pkg::*;

  logic valid; // buffer holds a flit
  logic [`NUM_PORTS-1:0] dest; // one-hot output choice
  flit_u flit;
  logic taken; // flit moved to an output

  modport buffer (
    output valid, dest, flit,
    input  taken
  );

  modport alloc (
    input  valid, dest, flit,
    output taken
  );

endinterface

`default_nettype wire

// File: verilog/router.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

module router #(
  parameter logic [`COORD_WIDTH-1:0] X_LOCATION = 2'd0,
  parameter logic [`COORD_WIDTH-1:0] Y_LOCATION = 2'd0
) (
  input  logic clk,
  input  logic reset,
  input  logic [`NUM_PORTS-1:0] in_req,
  input  logic [`FLIT_WIDTH-1:0] in_data [`NUM_PORTS], // PE, E, W, N, S
  output logic [`NUM_PORTS-1:0] in_ack,
  output logic [`NUM_PORTS-1:0] out_req,
  output logic [`FLIT_WIDTH-1:0] out_data [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] out_ack
);
  import noc_pkg::*;

  route_if rt [`NUM_PORTS] ();

  logic [`NUM_PORTS-1:0] load;
  logic [`NUM_PORTS-1:0] busy;
  flit_u out_flit [`NUM_PORTS];

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
    input_port #(
      .X_LOCATION(X_LOCATION),
      .Y_LOCATION(Y_LOCATION)
    ) u_input_port (
      .clk(clk),
      .reset(reset),
      .in_req(in_req[p]),
      .in_data(in_data[p]),
      .in_ack(in_ack[p]),
      .rt(rt[p])
    );

    output_port u_output_port (
      .clk(clk),
      .reset(reset),
      .load(load[p]),
      .flit(out_flit[p]),
      .busy(busy[p]),
      .out_req(out_req[p]),
      .out_data(out_data[p]),
      .out_ack(out_ack[p])
    );
  end

  switch_allocator u_switch_allocator (
    .clk(clk),
    .reset(reset),
    .rt(rt),
    .busy(busy),
    .load(load),
    .out_flit(out_flit)
  );

endmodule

`default_nettype wire

// File: verilog/switch_allocator.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

module switch_allocator (
  input  logic clk,
  input  logic reset,
  route_if.alloc rt [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] busy,
  output logic [`NUM_PORTS-1:0] load,
  output noc_pkg::flit_u out_flit [`NUM_PORTS]
);
  import noc_pkg::*;

  localparam int PTR_W = $clog2(`NUM_PORTS);

  logic [`NUM_PORTS-1:0] req_valid;
  logic [`NUM_PORTS-1:0] req_dest [`NUM_PORTS];
  flit_u in_flit [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] taken;
  logic [`NUM_PORTS-1:0] taken_next;
  logic [`NUM_PORTS-1:0] load_next;
  logic [`NUM_PORTS-1:0] req [`NUM_PORTS]; // per output, by input
  logic [`NUM_PORTS-1:0] gnt [`NUM_PORTS];
  logic [PTR_W-1:0] ptr [`NUM_PORTS];
  logic [PTR_W-1:0] ptr_next [`NUM_PORTS];
  flit_u sel_flit [`NUM_PORTS];

  for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_in
    assign req_valid[i] = rt[i].valid;
    assign req_dest[i] = rt[i].dest;
    assign in_flit[i] = rt[i].flit;
    assign rt[i].taken = taken[i];
  end

  // first requester at or after the pointer, wrapping around
  function automatic logic [`NUM_PORTS-1:0] rr_pick(input logic [`NUM_PORTS-1:0] r,
                                                    input logic [PTR_W-1:0] p);
    logic [`NUM_PORTS-1:0] g;
    logic found;
    int idx;
    g = '0;
    found = 1'b0;
    for (int k = 0; k < `NUM_PORTS; k++) begin
      idx = (int'(p) + k) % `NUM_PORTS;
      if (!found && r[idx]) begin
        g[idx] = 1'b1;
        found = 1'b1;
      end
    end
    return g;
  endfunction

  always_comb begin
    taken_next = '0;
    for (int o = 0; o < `NUM_PORTS; o++) begin
      for (int i = 0; i < `NUM_PORTS; i++) begin
        req[o][i] = req_valid[i] && !taken[i] && req_dest[i][o]; // skip flits already moved
      end
      gnt[o] = (busy[o] || load[o]) ? '0 : rr_pick(req[o], ptr[o]);
      load_next[o] = |gnt[o];
      taken_next = taken_next | gnt[o];
      sel_flit[o] = '0;
      ptr_next[o] = ptr[o];
      for (int i = 0; i < `NUM_PORTS; i++) begin
        if (gnt[o][i]) begin
          sel_flit[o] = in_flit[i];
          ptr_next[o] = PTR_W'((i + 1) % `NUM_PORTS);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      load <= '0;
      taken <= '0;
      for (int o = 0; o < `NUM_PORTS; o++) begin
        ptr[o] <= '0;
      end
    end else begin
      load <= load_next;
      taken <= taken_next;
      ptr <= ptr_next;
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      if (load_next[o]) begin
        out_flit[o] <= sel_flit[o];
      end
    end
  end

  // each active output moves exactly one input, and no input goes twice
  a_grant_onehot: assert property (
    @(posedge clk) disable iff (reset) $countones(taken_next) == $countones(load_next)
  );

endmodule

`default_nettype wire
